// File: logic_analyzer.f
src/la_pkg.sv
src/la_trigger.sv
src/la_fsm.sv
src/la_sample_buffer.sv
src/logic_analyzer.sv
sim/tb_logic_analyzer.sv

// File: Bender.yml
package:
  name: logic_analyzer

sources:
  # package first, then the blocks and the top level
  - src/la_pkg.sv
  - src/la_trigger.sv
  - src/la_fsm.sv
  - src/la_sample_buffer.sv
  - src/logic_analyzer.sv
  - target: simulation
    files:
      - sim/tb_logic_analyzer.sv

// File: sim/tb_logic_analyzer.sv
`timescale 1ns/1ps

module tb_logic_analyzer import la_pkg::*; ();

    localparam int RESET_CYCLES  = 16;
    localparam int ACCESS_CYCLES = 4;
    localparam int TRIG_OFFSET   = 300;
    localparam int NUM_RANDOM    = 12;
    localparam int IDLE_POLLS    = 100;
    localparam int MAX_POLLS     = 200;
    localparam int PARTIAL_DRAIN = 20;
    // one capture is a few writes, polling up to the limit and a full drain
    localparam int CAPTURE_CYCLES = (MAX_POLLS + 2 * SAMPLE_DEPTH + 16) * ACCESS_CYCLES;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + 4 * CAPTURE_CYCLES
        + (3 * NUM_RANDOM + 2 * IDLE_POLLS + MAX_POLLS + 64) * ACCESS_CYCLES + 1000;

    logic      clk;
    logic      rst_i;
    sample_t   probe_i;
    bus_addr_t addr_i;
    bus_data_t wdata_i;
    logic      rw_i;
    logic      valid_i;
    bus_addr_t addr_o;
    bus_data_t wdata_o;
    bus_data_t rdata_o;
    logic      rw_o;
    logic      valid_o;

    // last value written to each mapped address
    bus_data_t   shadow [8];
    bus_addr_t   rand_addrs [3] = '{TRIG_VALUE_ADDR, TRIG_MASK_ADDR, CAP_TRIG_LOC_ADDR};
    logic [31:0] rng_state;
    string       test_name;

    logic_analyzer uut (
        .clk     (clk),
        .rst_i   (rst_i),
        .probe_i (probe_i),
        .addr_i  (addr_i),
        .wdata_i (wdata_i),
        .rw_i    (rw_i),
        .valid_i (valid_i),
        .addr_o  (addr_o),
        .wdata_o (wdata_o),
        .rdata_o (rdata_o),
        .rw_o    (rw_o),
        .valid_o (valid_o)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // probe counts up by one every cycle
    initial begin
        probe_i = '0;
        forever begin
            @(posedge clk);
            #1 probe_i = probe_i + 1'b1;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        abort_run($sformatf("simulation timed out after %0d cycles", WATCHDOG_CYCLES));
    end

    function automatic logic [31:0] xorshift32();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // readback predicted from reset values and the host writes so far
    function automatic bus_data_t expected_reg(input bus_addr_t addr);
        case (addr)
            TRIG_MODE_ADDR:    return {14'd0, shadow[addr[2:0]][1:0]};
            TRIG_VALUE_ADDR,
            TRIG_MASK_ADDR,
            CAP_TRIG_LOC_ADDR: return shadow[addr[2:0]];
            default:           return '0;
        endcase
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input bus_data_t expected,
                              input bus_data_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("** Error: %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    task automatic check_addr(input string name, input bus_addr_t expected,
                              input bus_addr_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("** Error: %s: expected address %h, actual address %h",
                                name, expected, actual));
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            abort_run($sformatf("** Error: %s: expected flag %b, actual flag %b",
                                name, expected, actual));
        end
    endtask

    task automatic check_state(input string name, input cap_state_t expected,
                               input cap_state_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("** Error: %s: expected state %0d (%s), actual state %0d",
                                name, expected, expected.name(), actual));
        end
    endtask

    task automatic check_fill(input string name, input fill_t expected, input fill_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("** Error: %s: expected fill %0d, actual fill %0d",
                                name, expected, actual));
        end
    endtask

    task automatic check_sample(input string name, input sample_t expected,
                                input sample_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("** Error: %s: expected sample %h, actual sample %h",
                                name, expected, actual));
        end
    endtask

    // one strobe whose response leaves the chain three cycles later
    task automatic bus_access(input bus_addr_t addr, input bus_data_t data, input logic write,
                              output bus_data_t rdata);
        addr_i  = addr;
        wdata_i = data;
        rw_i    = write;
        valid_i = 1'b1;
        @(posedge clk);
        #1 valid_i = 1'b0;
        repeat (2) begin
            @(posedge clk);
            #1;
        end
        if (valid_o !== 1'b1) begin
            abort_run($sformatf("%s: no bus response 3 cycles after the access to address %h",
                                test_name, addr));
        end else begin
            // address, write data and direction pass every stage unchanged
            check_addr(test_name, addr, addr_o);
            check_data(test_name, data, wdata_o);
            check_flag(test_name, write, rw_o);
            rdata = rdata_o;
        end
    endtask

    task automatic bus_write(input bus_addr_t addr, input bus_data_t data);
        bus_data_t rdata;
        if (addr < 8) begin
            shadow[addr[2:0]] = data;
        end
        bus_access(addr, data, 1'b1, rdata);
    endtask

    task automatic bus_read(input bus_addr_t addr, output bus_data_t data);
        bus_access(addr, '0, 1'b0, data);
    endtask

    task automatic wait_for_state(input cap_state_t target);
        bus_data_t rd;
        int        polls;
        polls = 0;
        bus_read(CAP_STATE_ADDR, rd);
        while (rd[3:0] != target) begin
            polls++;
            if (polls >= MAX_POLLS) begin
                abort_run($sformatf("%s: state never reached %s", test_name, target.name()));
            end else begin
                bus_read(CAP_STATE_ADDR, rd);
            end
        end
    endtask

    // trigger value lies far enough ahead of the probe to reach CAP_IN_POSITION first
    task automatic arm_match_capture(input loc_t loc, output sample_t trig_value);
        trig_value = probe_i + sample_t'(TRIG_OFFSET);
        bus_write(TRIG_VALUE_ADDR, trig_value);
        bus_write(TRIG_MODE_ADDR, bus_data_t'(TRIG_MATCH));
        bus_write(CAP_TRIG_LOC_ADDR, bus_data_t'(loc));
        bus_write(CAP_STATE_ADDR, bus_data_t'(CAP_START));
    endtask

    task automatic drain_and_check(input sample_t trig_value);
        bus_data_t rd;
        sample_t   prev;
        logic      seen;
        bus_read(BUF_DATA_ADDR, rd);
        prev = sample_t'(rd);
        seen = (prev == trig_value);
        for (int i = 1; i < SAMPLE_DEPTH; i++) begin
            bus_read(BUF_DATA_ADDR, rd);
            check_sample(test_name, sample_t'(prev + 1'b1), sample_t'(rd));
            prev = sample_t'(rd);
            seen = seen || (prev == trig_value);
        end
        if (!seen) begin
            abort_run($sformatf("%s: trigger value %h missing from the captured samples",
                                test_name, trig_value));
        end else begin
            bus_read(BUF_SIZE_ADDR, rd);
            check_fill(test_name, '0, fill_t'(rd));
        end
    endtask

    task automatic capture_and_check(input loc_t loc);
        bus_data_t rd;
        sample_t   trig_value;
        arm_match_capture(loc, trig_value);
        wait_for_state(CAP_FILLED);
        bus_read(BUF_SIZE_ADDR, rd);
        check_fill(test_name, fill_t'(SAMPLE_DEPTH), fill_t'(rd));
        drain_and_check(trig_value);
    endtask

    initial begin
        bus_data_t rd;
        bus_data_t wr;
        sample_t   trig_value;

        rst_i     = 1'b1;
        addr_i    = '0;
        wdata_i   = '0;
        rw_i      = 1'b0;
        valid_i   = 1'b0;
        rng_state = 32'd99240;
        for (int a = 0; a < 8; a++) begin
            shadow[a] = '0;
        end
        shadow[TRIG_MASK_ADDR] = 16'hFFFF;

        test_name = "reset values";
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst_i = 1'b0;
        repeat (4) begin
            if (valid_o !== 1'b0) begin
                abort_run("valid_o was not low before the first bus access");
            end
            @(posedge clk);
            #1;
        end
        bus_read(CAP_STATE_ADDR, rd);
        check_state(test_name, CAP_IDLE, cap_state_t'(rd[3:0]));
        bus_read(BUF_SIZE_ADDR, rd);
        check_fill(test_name, '0, fill_t'(rd));
        bus_read(TRIG_MASK_ADDR, rd);
        check_data(test_name, expected_reg(TRIG_MASK_ADDR), rd);

        test_name = "register readback";
        for (int i = 0; i < NUM_RANDOM; i++) begin
            wr = bus_data_t'(xorshift32());
            bus_write(rand_addrs[i % 3], wr);
            bus_read(rand_addrs[i % 3], rd);
            check_data(test_name, expected_reg(rand_addrs[i % 3]), rd);
        end
        for (int i = 0; i < 3; i++) begin
            bus_read(rand_addrs[i], rd);
            check_data(test_name, expected_reg(rand_addrs[i]), rd);
        end
        // unmapped address passes the whole chain untouched
        bus_access(16'h0040, 16'h1234, 1'b0, rd);
        check_data(test_name, 16'h0000, rd);
        bus_write(TRIG_MASK_ADDR, 16'hFFFF);

        test_name = "match capture";
        capture_and_check(loc_t'(0));

        test_name = "positive trigger location";
        capture_and_check(loc_t'(10));

        test_name = "re-arm";
        bus_read(CAP_PRESENT_LOC_ADDR, rd);
        check_data(test_name, 16'h0000, rd);
        wr = bus_data_t'(xorshift32()) | 16'h8000;
        bus_write(CAP_TRIG_LOC_ADDR, wr);
        bus_read(CAP_PRESENT_LOC_ADDR, rd);
        check_data(test_name, wr, rd);
        arm_match_capture(loc_t'(wr), trig_value);
        wait_for_state(CAP_FILLED);
        repeat (PARTIAL_DRAIN) bus_read(BUF_DATA_ADDR, rd);
        bus_read(BUF_SIZE_ADDR, rd);
        check_fill(test_name, fill_t'(SAMPLE_DEPTH - PARTIAL_DRAIN), fill_t'(rd));
        // a fresh start empties the buffer so only the one-sample window remains
        arm_match_capture(loc_t'(wr), trig_value);
        bus_read(BUF_SIZE_ADDR, rd);
        check_fill(test_name, fill_t'(1), fill_t'(rd));
        wait_for_state(CAP_FILLED);
        bus_read(BUF_SIZE_ADDR, rd);
        check_fill(test_name, fill_t'(SAMPLE_DEPTH), fill_t'(rd));
        drain_and_check(trig_value);

        test_name = "trigger off";
        bus_write(TRIG_MODE_ADDR, bus_data_t'(TRIG_OFF));
        bus_read(TRIG_MODE_ADDR, rd);
        check_data(test_name, expected_reg(TRIG_MODE_ADDR), rd);
        bus_write(CAP_TRIG_LOC_ADDR, '0);
        bus_write(CAP_STATE_ADDR, bus_data_t'(CAP_START));
        wait_for_state(CAP_IN_POSITION);
        for (int i = 0; i < IDLE_POLLS; i++) begin
            bus_read(CAP_STATE_ADDR, rd);
            check_state(test_name, CAP_IN_POSITION, cap_state_t'(rd[3:0]));
            bus_read(BUF_SIZE_ADDR, rd);
            if (rd > SAMPLE_DEPTH) begin
                abort_run($sformatf("%s: fill count %0d went above the buffer depth",
                                    test_name, rd));
            end
        end

        $display("Simulation PASSED");
        $finish;
    end

endmodule

// File: src/logic_analyzer.sv
`timescale 1ns/1ps

module logic_analyzer import la_pkg::*; (
    input  logic      clk,
    input  logic      rst_i,
    input  sample_t   probe_i,

    // host side of the register bus
    input  bus_addr_t addr_i,
    input  bus_data_t wdata_i,
    input  logic      rw_i,
    input  logic      valid_i,

    output bus_addr_t addr_o,
    output bus_data_t wdata_o,
    output bus_data_t rdata_o,
    output logic      rw_o,
    output logic      valid_o
);

    // trigger to fsm bus stage
    bus_addr_t tf_addr;
    bus_data_t tf_wdata;
    bus_data_t tf_rdata;
    logic      tf_rw;
    logic      tf_valid;

    // fsm to buffer bus stage
    bus_addr_t fb_addr;
    bus_data_t fb_wdata;
    bus_data_t fb_rdata;
    logic      fb_rw;
    logic      fb_valid;

    sample_t   sample;
    logic      trig;
    logic      buf_acquire;
    logic      buf_pop;
    logic      buf_clear;
    fill_t     fill;

    la_trigger u_trigger (
        .clk      (clk),
        .rst_i    (rst_i),
        .probe_i  (probe_i),
        .addr_i   (addr_i),
        .wdata_i  (wdata_i),
        .rdata_i  ('0),
        .rw_i     (rw_i),
        .valid_i  (valid_i),
        .addr_o   (tf_addr),
        .wdata_o  (tf_wdata),
        .rdata_o  (tf_rdata),
        .rw_o     (tf_rw),
        .valid_o  (tf_valid),
        .sample_o (sample),
        .trig_o   (trig)
    );

    la_fsm u_fsm (
        .clk           (clk),
        .rst_i         (rst_i),
        .trig_i        (trig),
        .fill_i        (fill),
        .addr_i        (tf_addr),
        .wdata_i       (tf_wdata),
        .rdata_i       (tf_rdata),
        .rw_i          (tf_rw),
        .valid_i       (tf_valid),
        .addr_o        (fb_addr),
        .wdata_o       (fb_wdata),
        .rdata_o       (fb_rdata),
        .rw_o          (fb_rw),
        .valid_o       (fb_valid),
        .buf_acquire_o (buf_acquire),
        .buf_pop_o     (buf_pop),
        .buf_clear_o   (buf_clear)
    );

    la_sample_buffer u_buffer (
        .clk       (clk),
        .rst_i     (rst_i),
        .sample_i  (sample),
        .acquire_i (buf_acquire),
        .pop_i     (buf_pop),
        .clear_i   (buf_clear),
        .addr_i    (fb_addr),
        .wdata_i   (fb_wdata),
        .rdata_i   (fb_rdata),
        .rw_i      (fb_rw),
        .valid_i   (fb_valid),
        .fill_o    (fill),
        .addr_o    (addr_o),
        .wdata_o   (wdata_o),
        .rdata_o   (rdata_o),
        .rw_o      (rw_o),
        .valid_o   (valid_o)
    );

endmodule

// File: src/la_sample_buffer.sv
`timescale 1ns/1ps

module la_sample_buffer import la_pkg::*; (
    input  logic      clk,
    input  logic      rst_i,
    input  sample_t   sample_i,
    input  logic      acquire_i,
    input  logic      pop_i,
    input  logic      clear_i,

    // bus from the capture fsm
    input  bus_addr_t addr_i,
    input  bus_data_t wdata_i,
    input  bus_data_t rdata_i,
    input  logic      rw_i,
    input  logic      valid_i,

    output fill_t     fill_o,

    // bus towards the top-level outputs
    output bus_addr_t addr_o,
    output bus_data_t wdata_o,
    output bus_data_t rdata_o,
    output logic      rw_o,
    output logic      valid_o
);

    sample_t  mem [SAMPLE_DEPTH];
    buf_ptr_t wr_ptr;
    buf_ptr_t rd_ptr;
    fill_t    count;
    logic     bus_pop;
    logic     do_pop;
    logic     do_push;

    function automatic buf_ptr_t next_ptr(input buf_ptr_t ptr);
        if (ptr == buf_ptr_t'(SAMPLE_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // host drains through reads of the data address
    assign bus_pop = valid_i && !rw_i && (addr_i == BUF_DATA_ADDR);

    // bus and fsm pop in the same cycle still remove one sample
    assign do_pop  = (pop_i || bus_pop) && (count != '0);
    // a pop in the same cycle makes room for the push
    assign do_push = acquire_i && ((count != fill_t'(SAMPLE_DEPTH)) || do_pop);

    assign fill_o = count;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= sample_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i || clear_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

    // bus stage
    always_ff @(posedge clk) begin
        addr_o  <= addr_i;
        wdata_o <= wdata_i;
        rw_o    <= rw_i;
        rdata_o <= rdata_i;
        if (valid_i && !rw_i) begin
            case (addr_i)
                BUF_SIZE_ADDR: rdata_o <= bus_data_t'(count);
                BUF_DATA_ADDR: rdata_o <= mem[rd_ptr];
                default: ;
            endcase
        end
    end

endmodule

// File: src/la_fsm.sv
`timescale 1ns/1ps

module la_fsm import la_pkg::*; (
    input  logic      clk,
    input  logic      rst_i,
    input  logic      trig_i,
    input  fill_t     fill_i,

    // bus from the trigger block
    input  bus_addr_t addr_i,
    input  bus_data_t wdata_i,
    input  bus_data_t rdata_i,
    input  logic      rw_i,
    input  logic      valid_i,

    // bus towards the sample buffer
    output bus_addr_t addr_o,
    output bus_data_t wdata_o,
    output bus_data_t rdata_o,
    output logic      rw_o,
    output logic      valid_o,

    // buffer commands
    output logic      buf_acquire_o,
    output logic      buf_pop_o,
    output logic      buf_clear_o
);

    cap_state_t state;
    loc_t       trig_loc;
    loc_t       present_loc;
    logic       move_step;

    // still short of the trigger location, keep buffering while stepping
    assign move_step = (trig_loc > 0) && (present_loc < trig_loc);

    always_comb begin
        buf_acquire_o = 1'b0;
        buf_pop_o     = 1'b0;
        buf_clear_o   = 1'b0;
        case (state)
            CAP_START: begin
                buf_clear_o = 1'b1;
            end
            CAP_MOVE: begin
                buf_acquire_o = move_step;
            end
            CAP_IN_POSITION: begin
                // push and pop together gives a sliding pre-trigger window
                buf_acquire_o = 1'b1;
                buf_pop_o     = 1'b1;
            end
            CAP_FILLING: begin
                buf_acquire_o = 1'b1;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state       <= CAP_IDLE;
            trig_loc    <= '0;
            present_loc <= '0;
            valid_o     <= 1'b0;
        end else begin
            valid_o <= valid_i;

            case (state)
                CAP_IDLE, CAP_FILLED: begin
                    // waits here until the host writes the state again
                    present_loc <= (trig_loc < 0) ? trig_loc : loc_t'(0);
                end
                CAP_START: begin
                    state <= CAP_MOVE;
                end
                CAP_MOVE: begin
                    if (move_step) begin
                        present_loc <= present_loc + loc_t'(1);
                    end else begin
                        state <= CAP_IN_POSITION;
                    end
                end
                CAP_IN_POSITION: begin
                    if (trig_i) begin
                        state <= CAP_FILLING;
                    end
                end
                CAP_FILLING: begin
                    if (fill_i == fill_t'(SAMPLE_DEPTH)) begin
                        state <= CAP_FILLED;
                    end
                end
                default: begin
                    state <= CAP_IDLE;
                end
            endcase

            // host writes win over the machine's own update
            if (valid_i && rw_i) begin
                case (addr_i)
                    CAP_STATE_ADDR:       state <= cap_state_t'(wdata_i[3:0]);
                    CAP_TRIG_LOC_ADDR:    trig_loc <= loc_t'(wdata_i);
                    CAP_PRESENT_LOC_ADDR: present_loc <= loc_t'(wdata_i);
                    default: ;
                endcase
            end
        end
    end

    // bus stage
    always_ff @(posedge clk) begin
        addr_o  <= addr_i;
        wdata_o <= wdata_i;
        rw_o    <= rw_i;
        rdata_o <= rdata_i;
        if (valid_i && !rw_i) begin
            case (addr_i)
                CAP_STATE_ADDR:       rdata_o <= bus_data_t'(state);
                CAP_TRIG_LOC_ADDR:    rdata_o <= bus_data_t'(trig_loc);
                CAP_PRESENT_LOC_ADDR: rdata_o <= bus_data_t'(present_loc);
                default: ;
            endcase
        end
    end

endmodule

// File: src/la_trigger.sv
`timescale 1ns/1ps

module la_trigger import la_pkg::*; (
    input  logic      clk,
    input  logic      rst_i,
    input  sample_t   probe_i,

    // bus from the host side
    input  bus_addr_t addr_i,
    input  bus_data_t wdata_i,
    input  bus_data_t rdata_i,
    input  logic      rw_i,
    input  logic      valid_i,

    // bus towards the capture fsm
    output bus_addr_t addr_o,
    output bus_data_t wdata_o,
    output bus_data_t rdata_o,
    output logic      rw_o,
    output logic      valid_o,

    output sample_t   sample_o,
    output logic      trig_o
);

    trig_mode_t mode;
    sample_t    value;
    sample_t    mask;
    sample_t    masked;
    sample_t    prev_masked;

    assign masked = sample_o & mask;

    // probe is registered once, the rest of the design sees sample_o
    always_ff @(posedge clk) begin
        sample_o    <= probe_i;
        prev_masked <= masked;
    end

    always_comb begin
        case (mode)
            TRIG_MATCH:  trig_o = (masked == (value & mask));
            TRIG_CHANGE: trig_o = (masked != prev_masked);
            default:     trig_o = 1'b0;
        endcase
    end

    // control registers and the bus valid
    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_o <= 1'b0;
            mode    <= TRIG_OFF;
            value   <= '0;
            mask    <= '1;
        end else begin
            valid_o <= valid_i;
            if (valid_i && rw_i) begin
                case (addr_i)
                    TRIG_MODE_ADDR:  mode <= trig_mode_t'(wdata_i[1:0]);
                    TRIG_VALUE_ADDR: value <= wdata_i;
                    TRIG_MASK_ADDR:  mask <= wdata_i;
                    default: ;
                endcase
            end
        end
    end

    // bus stage, read data replaced only for our own addresses
    always_ff @(posedge clk) begin
        addr_o  <= addr_i;
        wdata_o <= wdata_i;
        rw_o    <= rw_i;
        rdata_o <= rdata_i;
        if (valid_i && !rw_i) begin
            case (addr_i)
                TRIG_MODE_ADDR:  rdata_o <= bus_data_t'(mode);
                TRIG_VALUE_ADDR: rdata_o <= value;
                TRIG_MASK_ADDR:  rdata_o <= mask;
                default: ;
            endcase
        end
    end

endmodule

// File: src/la_pkg.sv
package la_pkg;

    // register bus and probe widths
    typedef logic [15:0] bus_addr_t;
    typedef logic [15:0] bus_data_t;
    typedef logic [15:0] sample_t;
    typedef logic signed [15:0] loc_t;

    // samples held by one full capture
    localparam int SAMPLE_DEPTH = 64;

    // count has to reach SAMPLE_DEPTH itself, pointers only index it
    typedef logic [$clog2(SAMPLE_DEPTH + 1) - 1:0] fill_t;
    typedef logic [$clog2(SAMPLE_DEPTH) - 1:0] buf_ptr_t;

    typedef enum logic [3:0] {
        CAP_IDLE        = 4'd0,
        CAP_START       = 4'd1,
        CAP_MOVE        = 4'd2,
        CAP_IN_POSITION = 4'd3,
        CAP_FILLING     = 4'd4,
        CAP_FILLED      = 4'd5
    } cap_state_t;

    typedef enum logic [1:0] {
        TRIG_OFF    = 2'd0,
        TRIG_MATCH  = 2'd1,
        TRIG_CHANGE = 2'd2
    } trig_mode_t;

    // register map, one word per register
    localparam bus_addr_t TRIG_MODE_ADDR       = 16'd0;
    localparam bus_addr_t TRIG_VALUE_ADDR      = 16'd1;
    localparam bus_addr_t TRIG_MASK_ADDR       = 16'd2;
    localparam bus_addr_t CAP_STATE_ADDR       = 16'd3;
    localparam bus_addr_t CAP_TRIG_LOC_ADDR    = 16'd4;
    localparam bus_addr_t CAP_PRESENT_LOC_ADDR = 16'd5;
    localparam bus_addr_t BUF_SIZE_ADDR        = 16'd6;
    localparam bus_addr_t BUF_DATA_ADDR        = 16'd7;

endpackage
